// ==== Makefile ====
# Verilator build and run for the branch resolution pipeline

VERILATOR ?= verilator
TOP       ?= bru_pipeline_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

HEADERS := common/bru_consts.svh
SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bru/bru_ex_stage.sv ====
// branch execute and resolve
`include "bru_consts.svh"

module bru_ex_stage import bru_pkg::*; (
    input  logic              ex_valid,
    input  ex_task_t          ex_task,
    input  complete_bus_t     complete_bus_0,
    input  complete_bus_t     complete_bus_1,
    input  complete_bus_t     complete_bus_2,
    output logic              complete_valid,
    output logic              restart_valid,
    output restart_t          restart,
    output logic              predictor_update_valid,
    output predictor_update_t predictor_update
);

    word_t operand_a;
    word_t operand_b;
    pc_t   jr_target;
    pc_t   expected_pc;
    logic  branch_taken;

    // raw latched value or this cycle's bus data
    function automatic word_t select_operand(
        input operand_sel_t  sel,
        input word_t         raw,
        input complete_bus_t bus_0,
        input complete_bus_t bus_1,
        input complete_bus_t bus_2
    );
        case (sel)
            sel_bus0: return bus_0.data;
            sel_bus1: return bus_1.data;
            sel_bus2: return bus_2.data;
            default:  return raw;
        endcase
    endfunction

    ////////////////////////////////////////
    // operands

    assign operand_a = select_operand(ex_task.operand_0_sel, ex_task.operand_0,
                                      complete_bus_0, complete_bus_1, complete_bus_2);
    assign operand_b = select_operand(ex_task.operand_1_sel, ex_task.operand_1,
                                      complete_bus_0, complete_bus_1, complete_bus_2);

    // byte address in register, word pc bits 15..2
    assign jr_target = operand_a[`BRU_PC_WIDTH+1:2];

    ////////////////////////////////////////
    // resolution

    always_comb begin
        case (ex_task.op)
            op_beq:  branch_taken = (operand_a == operand_b);
            op_bne:  branch_taken = (operand_a != operand_b);
            default: branch_taken = 1'b0;
        endcase

        // fall-through unless taken or jr
        if (ex_task.op == op_jr) begin
            expected_pc = jr_target;
        end else if (branch_taken) begin
            expected_pc = ex_task.branch_pc;
        end else begin
            expected_pc = ex_task.pc_plus_1;
        end
    end

    ////////////////////////////////////////
    // outputs

    assign complete_valid = ex_valid;

    // wrong fetch path, restart at the resolved pc
    assign restart_valid = ex_valid && (ex_task.npc != expected_pc);
    assign restart       = '{rob_index:   ex_task.rob_index,
                             pc:          expected_pc,
                             safe_column: ex_task.safe_column};

    // jr has no btb or direction entry to train
    assign predictor_update_valid = ex_valid && (ex_task.op != op_jr);
    assign predictor_update       = '{index:  ex_task.btb_index,
                                      target: ex_task.branch_pc,
                                      taken:  branch_taken};

endmodule

// ==== bru/bru_operand_wakeup.sv ====
// operand tag match on complete buses
`include "bru_consts.svh"

module bru_operand_wakeup import bru_pkg::*; (
    input  source_status_t source,
    input  complete_bus_t  complete_bus_0,
    input  complete_bus_t  complete_bus_1,
    input  complete_bus_t  complete_bus_2,
    output logic           wakeup,
    output operand_sel_t   wakeup_sel
);

    complete_bus_t                   buses [`BRU_NUM_COMPLETE_BUS];
    logic [`BRU_NUM_COMPLETE_BUS-1:0] bus_match;

    assign buses[0] = complete_bus_0;
    assign buses[1] = complete_bus_1;
    assign buses[2] = complete_bus_2;

    // valid tag match per bus
    always_comb begin
        for (int i = 0; i < `BRU_NUM_COMPLETE_BUS; i++) begin
            bus_match[i] = buses[i].valid && (buses[i].tag == source.tag);
        end
    end

    // any match wakes the operand
    // walk down so the lowest bus number wins
    always_comb begin
        wakeup     = 1'b0;
        wakeup_sel = sel_raw;
        for (int i = `BRU_NUM_COMPLETE_BUS - 1; i >= 0; i--) begin
            if (bus_match[i]) begin
                wakeup     = 1'b1;
                wakeup_sel = operand_sel_t'(i[1:0]);
            end
        end
    end

endmodule

// ==== bru/bru_pipeline.sv ====
// branch resolution pipeline
module bru_pipeline import bru_pkg::*; (
    input  logic              CLK,
    input  logic              nRST,

    // dispatch
    input  logic              dispatch_valid,
    input  bru_task_t         dispatch_task,
    output logic              rs_full,

    // register file read
    output logic              reg_read_valid,
    output phys_tag_t         reg_read_tag_0,
    output phys_tag_t         reg_read_tag_1,
    input  logic              reg_read_serviced,
    input  word_t             reg_read_data_0,
    input  word_t             reg_read_data_1,

    // kill bus
    input  logic              kill_valid,
    input  rob_index_t        kill_rob_index,

    // complete buses
    input  complete_bus_t     complete_bus_0,
    input  complete_bus_t     complete_bus_1,
    input  complete_bus_t     complete_bus_2,

    // to rob and fetch
    output logic              complete_valid,
    output logic              restart_valid,
    output restart_t          restart,
    output logic              predictor_update_valid,
    output predictor_update_t predictor_update
);

    ////////////////////////////////////////
    // rs to ex latch

    logic     ex_valid;
    ex_task_t ex_task;

    // operand collection, one entry
    // a restart in ex flushes both stages
    bru_rs_stage u_rs_stage (
        .CLK               (CLK),
        .nRST              (nRST),
        .dispatch_valid    (dispatch_valid),
        .dispatch_task     (dispatch_task),
        .flush             (restart_valid),
        .kill_valid        (kill_valid),
        .kill_rob_index    (kill_rob_index),
        .complete_bus_0    (complete_bus_0),
        .complete_bus_1    (complete_bus_1),
        .complete_bus_2    (complete_bus_2),
        .reg_read_valid    (reg_read_valid),
        .reg_read_tag_0    (reg_read_tag_0),
        .reg_read_tag_1    (reg_read_tag_1),
        .reg_read_serviced (reg_read_serviced),
        .reg_read_data_0   (reg_read_data_0),
        .reg_read_data_1   (reg_read_data_1),
        .rs_full           (rs_full),
        .ex_valid          (ex_valid),
        .ex_task           (ex_task)
    );

    // resolution, single cycle, never stalls
    bru_ex_stage u_ex_stage (
        .ex_valid               (ex_valid),
        .ex_task                (ex_task),
        .complete_bus_0         (complete_bus_0),
        .complete_bus_1         (complete_bus_1),
        .complete_bus_2         (complete_bus_2),
        .complete_valid         (complete_valid),
        .restart_valid          (restart_valid),
        .restart                (restart),
        .predictor_update_valid (predictor_update_valid),
        .predictor_update       (predictor_update)
    );

endmodule

// ==== bru/bru_rs_stage.sv ====
// branch unit reservation station
`include "bru_consts.svh"

module bru_rs_stage import bru_pkg::*; (
    input  logic          CLK,
    input  logic          nRST,
    input  logic          dispatch_valid,
    input  bru_task_t     dispatch_task,
    input  logic          flush,
    input  logic          kill_valid,
    input  rob_index_t    kill_rob_index,
    input  complete_bus_t complete_bus_0,
    input  complete_bus_t complete_bus_1,
    input  complete_bus_t complete_bus_2,
    output logic          reg_read_valid,
    output phys_tag_t     reg_read_tag_0,
    output phys_tag_t     reg_read_tag_1,
    input  logic          reg_read_serviced,
    input  word_t         reg_read_data_0,
    input  word_t         reg_read_data_1,
    output logic          rs_full,
    output logic          ex_valid,
    output ex_task_t      ex_task
);

    ////////////////////////////////////////
    // state and wakeup

    // held task
    logic         rs_valid;
    logic         rs_valid_next;
    bru_task_t    rs_task;
    bru_task_t    rs_task_next;
    ex_task_t     ex_task_next;

    // bus matches per operand
    logic         wake_0;
    logic         wake_1;
    operand_sel_t wake_sel_0;
    operand_sel_t wake_sel_1;

    // leave conditions
    logic         kill_hit;
    logic         need_1;
    logic         settled_0;
    logic         settled_1;
    logic         read_needed;
    logic         can_leave;
    logic         stay;

    bru_operand_wakeup u_wakeup_0 (
        .source         (rs_task.source_0),
        .complete_bus_0 (complete_bus_0),
        .complete_bus_1 (complete_bus_1),
        .complete_bus_2 (complete_bus_2),
        .wakeup         (wake_0),
        .wakeup_sel     (wake_sel_0)
    );

    bru_operand_wakeup u_wakeup_1 (
        .source         (rs_task.source_1),
        .complete_bus_0 (complete_bus_0),
        .complete_bus_1 (complete_bus_1),
        .complete_bus_2 (complete_bus_2),
        .wakeup         (wake_1),
        .wakeup_sel     (wake_sel_1)
    );

    ////////////////////////////////////////
    // leave decision

    assign kill_hit = kill_valid && (kill_rob_index == rs_task.rob_index);

    // jr uses operand 0 only
    assign need_1    = rs_task.source_1.needed;
    assign settled_0 = rs_task.source_0.ready || wake_0;
    assign settled_1 = !need_1 || rs_task.source_1.ready || wake_1;

    // any operand still to come from the register file
    assign read_needed = rs_task.source_0.ready || (need_1 && rs_task.source_1.ready);

    // read only once the task could actually go
    assign reg_read_valid = rs_valid && !kill_hit && settled_0 && settled_1 && read_needed;
    assign reg_read_tag_0 = rs_task.source_0.tag;
    assign reg_read_tag_1 = rs_task.source_1.tag;

    assign can_leave = rs_valid && !kill_hit && settled_0 && settled_1
                       && (!read_needed || reg_read_serviced);
    assign stay      = rs_valid && !kill_hit && !can_leave;

    // a killed entry frees up right away
    assign rs_full = stay;

    ////////////////////////////////////////
    // next state

    always_comb begin
        rs_valid_next = rs_valid;
        rs_task_next  = rs_task;
        if (dispatch_valid) begin
            rs_valid_next = 1'b1;
            rs_task_next  = dispatch_task;
        end else if (kill_hit || can_leave) begin
            rs_valid_next = 1'b0;
        end else if (stay) begin
            // bus tag seen, value sits in the register file from now on
            if (wake_0) begin
                rs_task_next.source_0.ready = 1'b1;
            end
            if (wake_1 && need_1) begin
                rs_task_next.source_1.ready = 1'b1;
            end
        end
    end

    // ex latch contents
    // a ready operand wins over a same-cycle bus match
    always_comb begin
        ex_task_next.op            = rs_task.op;
        ex_task_next.operand_0     = reg_read_data_0;
        ex_task_next.operand_1     = reg_read_data_1;
        ex_task_next.operand_0_sel = rs_task.source_0.ready ? sel_raw : wake_sel_0;
        ex_task_next.operand_1_sel = (!need_1 || rs_task.source_1.ready) ? sel_raw : wake_sel_1;
        ex_task_next.btb_index     = rs_task.pc[`BRU_BTB_INDEX_WIDTH-1:0];
        ex_task_next.branch_pc     = rs_task.pc + pc_t'(1)
                                     + rs_task.imm16[`BRU_PC_WIDTH-1:0];
        ex_task_next.pc_plus_1     = rs_task.pc + pc_t'(1);
        ex_task_next.npc           = rs_task.npc;
        ex_task_next.safe_column   = rs_task.safe_column;
        ex_task_next.rob_index     = rs_task.rob_index;
    end

    ////////////////////////////////////////
    // registers

    // flush also drops a same-cycle dispatch
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rs_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else if (flush) begin
            rs_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            rs_valid <= rs_valid_next;
            ex_valid <= can_leave;
        end
    end

    always_ff @(posedge CLK) begin
        rs_task <= rs_task_next;
        ex_task <= ex_task_next;
    end

endmodule

// ==== common/bru_consts.svh ====
// branch unit widths and counts
`ifndef BRU_CONSTS_SVH
`define BRU_CONSTS_SVH

////////////////////////////////////////
// datapath

// register data word
`define BRU_WORD_WIDTH 32
// word-addressed pc, one step per instruction
`define BRU_PC_WIDTH 14
// immediate field of beq/bne
`define BRU_IMM_WIDTH 16

////////////////////////////////////////
// core bookkeeping

`define BRU_PHYS_TAG_WIDTH 6
`define BRU_ROB_INDEX_WIDTH 6
// checkpoint column restored on restart
`define BRU_CHECKPOINT_WIDTH 3
// btb and direction predictor index, low pc bits
`define BRU_BTB_INDEX_WIDTH 8

// alu 0, alu 1, load queue
`define BRU_NUM_COMPLETE_BUS 3

`endif

// ==== common/bru_pkg.sv ====
// branch unit shared types
`include "bru_consts.svh"

package bru_pkg;

    ////////////////////////////////////////
    // scalar types

    typedef logic [`BRU_WORD_WIDTH-1:0]       word_t;
    typedef logic [`BRU_PC_WIDTH-1:0]         pc_t;
    typedef logic [`BRU_PHYS_TAG_WIDTH-1:0]   phys_tag_t;
    typedef logic [`BRU_ROB_INDEX_WIDTH-1:0]  rob_index_t;
    typedef logic [`BRU_CHECKPOINT_WIDTH-1:0] checkpoint_t;
    typedef logic [`BRU_BTB_INDEX_WIDTH-1:0]  btb_index_t;

    // branch ops handled here
    typedef enum logic [1:0] {
        op_beq = 2'd0,
        op_bne = 2'd1,
        op_jr  = 2'd2
    } bru_op_t;

    // where an operand comes from in ex
    // bus values are picked up one cycle after the tag
    typedef enum logic [1:0] {
        sel_bus0 = 2'd0,
        sel_bus1 = 2'd1,
        sel_bus2 = 2'd2,
        sel_raw  = 2'd3
    } operand_sel_t;

    ////////////////////////////////////////
    // payloads

    // one source operand as renamed
    typedef struct packed {
        logic      needed;
        // value already in the register file
        logic      ready;
        phys_tag_t tag;
    } source_status_t;

    // dispatch payload
    typedef struct packed {
        bru_op_t                  op;
        source_status_t           source_0;
        source_status_t           source_1;
        logic [`BRU_IMM_WIDTH-1:0] imm16;
        pc_t                      pc;
        // predicted next pc, checked in ex
        pc_t                      npc;
        checkpoint_t              safe_column;
        rob_index_t               rob_index;
    } bru_task_t;

    // one complete bus, tag now and data next cycle
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        word_t     data;
    } complete_bus_t;

    // rs to ex latch
    typedef struct packed {
        bru_op_t      op;
        word_t        operand_0;
        word_t        operand_1;
        operand_sel_t operand_0_sel;
        operand_sel_t operand_1_sel;
        btb_index_t   btb_index;
        pc_t          branch_pc;
        pc_t          pc_plus_1;
        pc_t          npc;
        checkpoint_t  safe_column;
        rob_index_t   rob_index;
    } ex_task_t;

    // restart request to rob
    typedef struct packed {
        rob_index_t  rob_index;
        pc_t         pc;
        checkpoint_t safe_column;
    } restart_t;

    // btb and direction predictor training
    typedef struct packed {
        btb_index_t index;
        pc_t        target;
        logic       taken;
    } predictor_update_t;

endpackage

// ==== compile.f ====
+incdir+common
common/bru_pkg.sv
bru/bru_operand_wakeup.sv
bru/bru_ex_stage.sv
bru/bru_rs_stage.sv
bru/bru_pipeline.sv
verification/bru_pipeline_tb.sv

// ==== verification/bru_pipeline_tb.sv ====
// branch pipeline testbench
`include "bru_consts.svh"

module bru_pipeline_tb import bru_pkg::*; ();

    localparam int CLK_PERIOD     = 40;
    localparam int NUM_ROWS       = 12;
    localparam int STALL_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int QUIET_CYCLES   = 10;

    typedef enum logic [2:0] {
        mode_read, mode_forward, mode_stall, mode_kill, mode_flush
    } mode_t;

    // one table row with hand-derived restart and taken
    typedef struct packed {
        bru_op_t                   op;
        mode_t                     mode;
        pc_t                       pc;
        logic [`BRU_IMM_WIDTH-1:0] imm;
        logic                      same;
        logic                      npc_ok;
        logic                      exp_restart;
        logic                      exp_taken;
    } row_t;

    logic              CLK;
    logic              nRST;
    logic              dispatch_valid;
    bru_task_t         dispatch_task;
    logic              rs_full;
    logic              reg_read_valid;
    phys_tag_t         reg_read_tag_0;
    phys_tag_t         reg_read_tag_1;
    logic              reg_read_serviced;
    word_t             reg_read_data_0;
    word_t             reg_read_data_1;
    logic              kill_valid;
    rob_index_t        kill_rob_index;
    complete_bus_t     buses [3];
    logic              complete_valid;
    logic              restart_valid;
    restart_t          restart;
    logic              predictor_update_valid;
    predictor_update_t predictor_update;

    // register file and bus model state
    word_t     regfile [64];
    word_t     next_data [3];
    logic      pend_valid [3];
    phys_tag_t pend_tag [3];
    word_t     pend_data [3];
    row_t      table_rows [NUM_ROWS];
    logic [31:0] lfsr;
    int        errors;
    int        rows_passed;
    int        rows_failed;

    bru_pipeline UUT (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .dispatch_valid         (dispatch_valid),
        .dispatch_task          (dispatch_task),
        .rs_full                (rs_full),
        .reg_read_valid         (reg_read_valid),
        .reg_read_tag_0         (reg_read_tag_0),
        .reg_read_tag_1         (reg_read_tag_1),
        .reg_read_serviced      (reg_read_serviced),
        .reg_read_data_0        (reg_read_data_0),
        .reg_read_data_1        (reg_read_data_1),
        .kill_valid             (kill_valid),
        .kill_rob_index         (kill_rob_index),
        .complete_bus_0         (buses[0]),
        .complete_bus_1         (buses[1]),
        .complete_bus_2         (buses[2]),
        .complete_valid         (complete_valid),
        .restart_valid          (restart_valid),
        .restart                (restart),
        .predictor_update_valid (predictor_update_valid),
        .predictor_update       (predictor_update)
    );

    // register file answers in the same cycle
    assign reg_read_data_0 = regfile[reg_read_tag_0];
    assign reg_read_data_1 = regfile[reg_read_tag_1];

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    ////////////////////////////////////////
    // helpers

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic random_word(output word_t w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    // next pc from the resolution rule
    function automatic pc_t resolved_pc(input row_t row, input word_t a, input word_t b);
        logic taken;
        if (row.op == op_jr) begin
            return a[`BRU_PC_WIDTH+1:2];
        end
        taken = (row.op == op_beq) ? (a == b) : (a != b);
        return taken ? row.pc + pc_t'(1) + row.imm[`BRU_PC_WIDTH-1:0] : row.pc + pc_t'(1);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("at %0t: %s", $time, msg);
        errors++;
    endtask

    // tag now and data on the following cycle
    task automatic announce(input int i, input phys_tag_t tag, input word_t data);
        pend_valid[i] = 1'b1;
        pend_tag[i]   = tag;
        pend_data[i]  = data;
    endtask

    task automatic bus_step();
        for (int i = 0; i < 3; i++) begin
            buses[i].data  = next_data[i];
            buses[i].valid = pend_valid[i];
            buses[i].tag   = pend_tag[i];
            next_data[i]   = pend_data[i];
            pend_valid[i]  = 1'b0;
            pend_data[i]   = '0;
        end
    endtask

    task automatic load_table();
        table_rows[0]  = '{op_beq, mode_read, 14'h0100, 16'h0010, 1'b1, 1'b1, 1'b0, 1'b1};
        table_rows[1]  = '{op_beq, mode_read, 14'h0200, 16'h0020, 1'b0, 1'b1, 1'b0, 1'b0};
        table_rows[2]  = '{op_bne, mode_read, 14'h0300, 16'hc005, 1'b1, 1'b0, 1'b1, 1'b0};
        // target wraps past the top of the pc range
        table_rows[3]  = '{op_bne, mode_read, 14'h3ffe, 16'h0004, 1'b0, 1'b0, 1'b1, 1'b1};
        table_rows[4]  = '{op_jr, mode_read, 14'h0400, 16'h0000, 1'b0, 1'b1, 1'b0, 1'b0};
        table_rows[5]  = '{op_jr, mode_read, 14'h0500, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b0};
        table_rows[6]  = '{op_beq, mode_forward, 14'h0600, 16'h0030, 1'b1, 1'b1, 1'b0, 1'b1};
        table_rows[7]  = '{op_bne, mode_forward, 14'h0700, 16'h0040, 1'b0, 1'b0, 1'b1, 1'b1};
        table_rows[8]  = '{op_beq, mode_stall, 14'h0800, 16'h0050, 1'b0, 1'b1, 1'b0, 1'b0};
        table_rows[9]  = '{op_bne, mode_kill, 14'h0900, 16'h0060, 1'b0, 1'b1, 1'b0, 1'b0};
        table_rows[10] = '{op_beq, mode_flush, 14'h0a00, 16'h0070, 1'b0, 1'b0, 1'b1, 1'b0};
        // must complete normally after the flush
        table_rows[11] = '{op_beq, mode_read, 14'h0b00, 16'h0080, 1'b1, 1'b1, 1'b0, 1'b1};
    endtask

    ////////////////////////////////////////
    // result checks

    task automatic check_completion(input row_t row, input int idx, input pc_t exp_pc,
                                    input rob_index_t rob);
        pc_t target;
        target = row.pc + pc_t'(1) + row.imm[`BRU_PC_WIDTH-1:0];
        if (restart_valid !== row.exp_restart)
            report_mismatch("restart_valid", 32'(row.exp_restart), 32'(restart_valid));
        if (row.exp_restart && restart.pc !== exp_pc)
            report_mismatch("restart.pc", 32'(exp_pc), 32'(restart.pc));
        if (row.exp_restart && restart.rob_index !== rob)
            report_mismatch("restart.rob_index", 32'(rob), 32'(restart.rob_index));
        if (row.exp_restart && restart.safe_column !== checkpoint_t'(idx))
            report_mismatch("restart.safe_column", 32'(idx), 32'(restart.safe_column));
        // jr trains nothing
        if (predictor_update_valid !== (row.op != op_jr))
            report_mismatch("predictor_update_valid", 32'(row.op != op_jr),
                            32'(predictor_update_valid));
        if (row.op != op_jr && predictor_update.target !== target)
            report_mismatch("predictor_update.target", 32'(target),
                            32'(predictor_update.target));
        if (row.op != op_jr && predictor_update.index !== row.pc[`BRU_BTB_INDEX_WIDTH-1:0])
            report_mismatch("predictor_update.index", 32'(row.pc[`BRU_BTB_INDEX_WIDTH-1:0]),
                            32'(predictor_update.index));
        if (row.op != op_jr && predictor_update.taken !== row.exp_taken)
            report_mismatch("predictor_update.taken", 32'(row.exp_taken),
                            32'(predictor_update.taken));
    endtask

    ////////////////////////////////////////
    // one table row

    task automatic run_row(input int idx, input row_t row);
        word_t      a;
        word_t      b;
        pc_t        exp_pc;
        phys_tag_t  t0;
        phys_tag_t  t1;
        rob_index_t rob;
        bru_task_t  dtask;
        bru_task_t  second;
        logic       from_rf;
        logic       seen;
        logic       done;
        int         cycles;
        int         exp_latency;
        int         errors_before;
        errors_before = errors;
        random_word(a);
        random_word(b);
        if (row.same)
            b = a;
        else if (b == a)
            b = ~a;
        exp_pc  = resolved_pc(row, a, b);
        t0      = phys_tag_t'(2 * idx + 1);
        t1      = phys_tag_t'(2 * idx + 2);
        rob     = rob_index_t'(idx + 8);
        from_rf = row.mode inside {mode_read, mode_stall, mode_flush};
        exp_latency = (row.mode == mode_stall) ? STALL_CYCLES + 2 : 2;
        // bus rows must not pick up the register file copy
        regfile[t0] = from_rf ? a : ~a;
        regfile[t1] = from_rf ? b : ~b;

        dtask.op              = row.op;
        dtask.source_0        = '{needed: 1'b1, ready: from_rf, tag: t0};
        dtask.source_1        = '{needed: row.op != op_jr, ready: from_rf && row.op != op_jr,
                                  tag: t1};
        dtask.imm16           = row.imm;
        dtask.pc              = row.pc;
        dtask.npc             = row.npc_ok ? exp_pc : exp_pc + pc_t'(3);
        dtask.safe_column     = checkpoint_t'(idx);
        dtask.rob_index       = rob;
        // dropped by the restart of the first
        second                = dtask;
        second.rob_index      = rob ^ rob_index_t'(6'h20);

        @(negedge CLK);
        dispatch_valid    = 1'b1;
        dispatch_task     = dtask;
        reg_read_serviced = (row.mode != mode_stall);
        bus_step();
        cycles = 0;
        seen   = 1'b0;
        done   = 1'b0;
        while (!done) begin
            @(negedge CLK);
            cycles++;
            dispatch_valid = 1'b0;
            kill_valid     = 1'b0;
            if (row.mode == mode_forward && cycles == 1) begin
                announce(idx % 3, t0, a);
                announce((idx + 1) % 3, t1, b);
            end
            if (row.mode == mode_stall && cycles == STALL_CYCLES + 1)
                reg_read_serviced = 1'b1;
            // wrong rob index first, then the real one
            if (row.mode == mode_kill && cycles == 2) begin
                kill_valid     = 1'b1;
                kill_rob_index = rob ^ rob_index_t'(1);
            end
            if (row.mode == mode_kill && cycles == 4) begin
                kill_valid     = 1'b1;
                kill_rob_index = rob;
            end
            // operands show up only after the kill so a live entry would complete
            if (row.mode == mode_kill && cycles == 5) begin
                announce(0, t0, a);
                announce(1, t1, b);
            end
            if (row.mode == mode_flush && cycles == 2) begin
                dispatch_valid = 1'b1;
                dispatch_task  = second;
            end
            bus_step();
            #(CLK_PERIOD / 4);

            if (complete_valid) begin
                if (seen || row.mode == mode_kill) begin
                    report_problem("complete_valid rose for a killed or dropped task");
                end else begin
                    seen = 1'b1;
                    if (cycles != exp_latency)
                        report_mismatch("complete latency", 32'(exp_latency), 32'(cycles));
                    check_completion(row, idx, exp_pc, rob);
                end
            end
            if (reg_read_valid === 1'b1 && reg_read_tag_0 !== t0)
                report_mismatch("reg_read_tag_0", 32'(t0), 32'(reg_read_tag_0));
            if (reg_read_valid === 1'b1 && row.op != op_jr && reg_read_tag_1 !== t1)
                report_mismatch("reg_read_tag_1", 32'(t1), 32'(reg_read_tag_1));
            if (row.mode == mode_forward && reg_read_valid !== 1'b0)
                report_mismatch("reg_read_valid", 32'(0), 32'(reg_read_valid));
            if (row.mode == mode_stall && cycles <= STALL_CYCLES) begin
                if (rs_full !== 1'b1)
                    report_mismatch("rs_full", 32'(1), 32'(rs_full));
                if (reg_read_valid !== 1'b1)
                    report_mismatch("reg_read_valid", 32'(1), 32'(reg_read_valid));
            end
            if (row.mode == mode_kill && rs_full !== (cycles < 4))
                report_mismatch("rs_full", 32'(cycles < 4), 32'(rs_full));

            if (row.mode == mode_kill || row.mode == mode_flush) begin
                done = (cycles >= QUIET_CYCLES);
            end else if (seen) begin
                done = 1'b1;
            end else if (cycles >= TIMEOUT_CYCLES) begin
                report_problem("timed out waiting for complete_valid");
                done = 1'b1;
            end
        end
        if (row.mode == mode_flush && !seen)
            report_problem("mispredicted task never completed");

        if (errors == errors_before) begin
            rows_passed++;
            $display("row %0d %s %s ok", idx, row.op.name(), row.mode.name());
        end else begin
            rows_failed++;
            $display("row %0d %s %s failed", idx, row.op.name(), row.mode.name());
        end
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        errors            = 0;
        rows_passed       = 0;
        rows_failed       = 0;
        lfsr              = 32'hd332;
        nRST              = 1'b0;
        dispatch_valid    = 1'b0;
        dispatch_task     = '0;
        reg_read_serviced = 1'b0;
        kill_valid        = 1'b0;
        kill_rob_index    = '0;
        for (int i = 0; i < 3; i++) begin
            buses[i]      = '0;
            next_data[i]  = '0;
            pend_valid[i] = 1'b0;
            pend_tag[i]   = '0;
            pend_data[i]  = '0;
        end
        // fill depends on every address bit
        for (int i = 0; i < 64; i++) begin
            regfile[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);
        end
        load_table();

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #(CLK_PERIOD / 4);
        // all handshake outputs idle out of reset
        if (rs_full !== 1'b0)
            report_mismatch("rs_full", 32'(0), 32'(rs_full));
        if (reg_read_valid !== 1'b0)
            report_mismatch("reg_read_valid", 32'(0), 32'(reg_read_valid));
        if (complete_valid !== 1'b0)
            report_mismatch("complete_valid", 32'(0), 32'(complete_valid));
        if (restart_valid !== 1'b0)
            report_mismatch("restart_valid", 32'(0), 32'(restart_valid));
        if (predictor_update_valid !== 1'b0)
            report_mismatch("predictor_update_valid", 32'(0), 32'(predictor_update_valid));

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r, table_rows[r]);
        end

        $display("%0d rows run, %0d passed, %0d failed, %0d errors",
                 NUM_ROWS, rows_passed, rows_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
